// File: mips_exec_top.f
+incdir+dv
src/mips_exec_pkg.sv
src/regfile.sv
src/alu.sv
src/exec_ctrl.sv
src/mips_exec_top.sv
dv/tb_mips_exec.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  # Package first, top level last
  - files:
      - src/mips_exec_pkg.sv
      - src/regfile.sv
      - src/alu.sv
      - src/exec_ctrl.sv
      - src/mips_exec_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mips_exec.sv

// File: dv/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////////////////////////
// Model state
////////////////////////////////////////

logic [31:0] model_regs [32];   // r0 entry never written
logic [31:0] model_hi;
logic [31:0] model_lo;
alu_flags_t  model_flags;       // Status register image
logic [31:0] lcg_state = 32'h5e523163;

// Reset contents, stack pointer at 0x200
function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_regs[REG_SP] = SP_RESET;
    model_hi    = '0;
    model_lo    = '0;
    model_flags = '0;
endfunction

// Host write, r0 dropped
function automatic void model_write(logic [7:0] adr, logic [31:0] dat);
    if (adr <= ADR_REG_LAST && adr[6:2] != 5'd0) model_regs[adr[6:2]] = dat;
    if (adr == ADR_HI) model_hi = dat;
    if (adr == ADR_LO) model_lo = dat;
endfunction

function automatic logic [31:0] model_read(logic [7:0] adr);
    if (adr <= ADR_REG_LAST) return model_regs[adr[6:2]];
    if (adr == ADR_HI) return model_hi;
    if (adr == ADR_LO) return model_lo;
    if (adr == ADR_STATUS) return {30'b0, model_flags.illegal, model_flags.zero};
    return '0;   // Command register reads zero
endfunction

////////////////////////////////////////
// Execute one command
////////////////////////////////////////

function automatic void model_exec(exec_cmd_t cmd);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] prod;
    a   = model_regs[cmd.rs];
    b   = model_regs[cmd.rt];
    res = '0;
    if (cmd.opcode > 4'd8) begin
        model_flags = '{illegal: 1'b1, zero: 1'b0};   // Nothing else moves
        return;
    end
    case (cmd.opcode)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_MFHI: res = model_hi;
        OP_MFLO: res = model_lo;
        OP_MULTU: begin
            prod     = {32'b0, a} * {32'b0, b};
            model_hi = prod[63:32];
            model_lo = prod[31:0];
        end
        OP_DIVU: begin
            model_hi = (b == '0) ? '0 : a % b;   // Remainder
            model_lo = (b == '0) ? '0 : a / b;   // Quotient
        end
        default: ;
    endcase
    if (cmd.opcode == OP_MULTU || cmd.opcode == OP_DIVU) begin
        model_flags = '{illegal: 1'b0, zero: (model_hi == '0 && model_lo == '0)};
    end else begin
        model_flags = '{illegal: 1'b0, zero: (res == '0)};
        if (cmd.rd != 5'd0) model_regs[cmd.rd] = res;
    end
endfunction

// LCG step, upper bits are the useful ones
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

// File: dv/tb_mips_exec.sv
module tb_mips_exec
    import mips_exec_pkg::*;
();

    typedef struct packed {
        logic [7:0]  adr;
        logic [31:0] got;
        logic [31:0] exp;
    } check_t;

    logic    clock;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    check_t check_q [$];       // Reads waiting for compare
    int     last_edges;        // Rising edges from request to ack
    int     checks       = 0;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     test_checks  = 0;  // Counts at test start
    int     test_errors  = 0;

    `include "ref_model.svh"

    mips_exec_top mips_exec_top_i (
        .clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers and bus tasks
    ////////////////////////////////////////

    function automatic logic [7:0] reg_adr(logic [4:0] idx);
        return {1'b0, idx, 2'b00};
    endfunction

    function automatic exec_cmd_t make_cmd(logic [3:0] op, logic [4:0] rd,
                                           logic [4:0] rs, logic [4:0] rt);
        return exec_cmd_t'({op, rd, rs, rt});
    endfunction

    function automatic string adr_name(logic [7:0] adr);
        if (adr <= ADR_REG_LAST) return $sformatf("r%0d", adr[6:2]);
        if (adr == ADR_HI) return "hi";
        if (adr == ADR_LO) return "lo";
        return "status";
    endfunction

    // One classic cycle with ack sampled mid-cycle
    task automatic wb_transfer(logic we, logic [7:0] adr, logic [31:0] dat,
                               output logic [31:0] rd_dat);
        last_edges = 0;
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clock);   // No ack expected before the first edge
        while (!wb_rsp.ack && last_edges < 20) begin
            @(posedge clock);
            last_edges++;
            @(negedge clock);
        end
        rd_dat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            $display("No ack within 20 cycles for address %h", adr);
            errors++;
        end
        @(posedge clock);
        wb_req <= '0;   // Drop stb after ack
    endtask

    task automatic host_write(logic [7:0] adr, logic [31:0] dat);
        logic [31:0] rd_dat;
        wb_transfer(1'b1, adr, dat, rd_dat);
        model_write(adr, dat);
    endtask

    task automatic host_read(logic [7:0] adr);
        logic [31:0] rd_dat;
        check_t      c;
        wb_transfer(1'b0, adr, 32'h0, rd_dat);
        c = '{adr: adr, got: rd_dat, exp: model_read(adr)};
        check_q.push_back(c);
    endtask

    task automatic run_cmd(exec_cmd_t cmd);
        logic [31:0] rd_dat;
        wb_transfer(1'b1, ADR_CMD, {13'b0, cmd}, rd_dat);
        model_exec(cmd);
    endtask

    task automatic read_hilo_status();
        host_read(ADR_HI);
        host_read(ADR_LO);
        host_read(ADR_STATUS);
    endtask

    task automatic check_edges(string what, int expected);
        checks++;
        assert (last_edges == expected) else begin
            $display("Fail ack_edges (%s) got %h expected %h", what, last_edges, expected);
            errors++;
        end
    endtask

    // Drains queued reads against the model
    initial begin
        check_t c;
        forever begin
            @(posedge clock);
            while (check_q.size() > 0) begin
                c = check_q.pop_front();
                checks++;
                assert (c.got === c.exp) else begin
                    $display("Fail %s got %h expected %h", adr_name(c.adr), c.got, c.exp);
                    errors++;
                end
            end
        end
    end

    task automatic finish_test(string name);
        int t;
        t = 0;
        while (check_q.size() > 0 && t < 20) begin
            @(posedge clock);
            t++;
        end
        if (check_q.size() > 0) begin
            $display("Compare queue still holds reads at end of %s", name);
            errors++;
        end
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("Test %-16s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic read_reset_state();
        for (int i = 0; i < 32; i++) host_read(reg_adr(5'(i)));
        read_hilo_status();
    endtask

    task automatic reg_write_readback();
        for (int i = 1; i < 32; i++) host_write(reg_adr(5'(i)), lcg_next());
        for (int i = 0; i < 32; i++) host_read(reg_adr(5'(i)));
        host_write(reg_adr(5'd0), lcg_next());   // Ignored
        host_read(reg_adr(5'd0));
    endtask

    task automatic random_alu_cmds();
        logic [31:0] r;
        logic [4:0]  rd;
        host_write(reg_adr(5'd1), 32'h8000_0000);   // Negative SLT operand
        host_write(reg_adr(5'd2), 32'd5);
        run_cmd(make_cmd(OP_SLT, 5'd3, 5'd1, 5'd2));
        host_read(reg_adr(5'd3));
        run_cmd(make_cmd(OP_SLT, 5'd4, 5'd2, 5'd1));
        host_read(reg_adr(5'd4));
        host_read(ADR_STATUS);
        for (int n = 0; n < 200; n++) begin
            if (n % 8 == 0) begin   // Refresh an operand
                r = lcg_next();
                host_write(reg_adr(r[31:27]), lcg_next());
            end
            r  = lcg_next();
            rd = (n % 25 == 0) ? 5'd0 : r[31:27];
            run_cmd(make_cmd(4'((r >> 8) % 5), rd, r[26:22], r[21:17]));
            host_read(reg_adr(rd));
            host_read(ADR_STATUS);
        end
    endtask

    task automatic mul_div_cmds();
        logic [31:0] r;
        logic [31:0] b;
        host_write(reg_adr(5'd1), 32'hFFFF_FFFF);
        host_write(reg_adr(5'd2), 32'hFFFF_FFFE);
        run_cmd(make_cmd(OP_MULTU, 5'd0, 5'd1, 5'd2));   // Upper half nonzero
        read_hilo_status();
        run_cmd(make_cmd(OP_DIVU, 5'd0, 5'd1, 5'd0));    // Divide by r0
        read_hilo_status();
        for (int n = 0; n < 30; n++) begin
            b = lcg_next();
            if (n % 6 == 2) b = '0;
            else if (n % 3 == 0) b = b >> 24;   // Small divisor
            host_write(reg_adr(5'd1), lcg_next());
            host_write(reg_adr(5'd2), b);
            run_cmd(make_cmd(n[0] ? OP_DIVU : OP_MULTU, 5'd0, 5'd1, 5'd2));
            read_hilo_status();
            r = lcg_next();
            run_cmd(make_cmd(OP_MFHI, r[31:27], 5'd0, 5'd0));
            host_read(reg_adr(r[31:27]));
            run_cmd(make_cmd(OP_MFLO, r[26:22], 5'd0, 5'd0));
            host_read(reg_adr(r[26:22]));
            host_read(ADR_STATUS);
        end
    endtask

    task automatic illegal_and_hilo();
        logic [31:0] r;
        host_write(ADR_HI, lcg_next());
        host_write(ADR_LO, lcg_next());
        host_read(ADR_HI);
        host_read(ADR_LO);
        for (int code = 9; code < 16; code++) begin
            r = lcg_next();
            run_cmd(make_cmd(4'(code), r[31:27], r[26:22], r[21:17]));
            read_hilo_status();
            host_read(reg_adr(r[31:27]));
        end
        for (int i = 0; i < 32; i++) host_read(reg_adr(5'(i)));
        run_cmd(make_cmd(OP_OR, 5'd7, 5'd29, 5'd0));   // Legal again
        host_read(ADR_STATUS);
        host_read(reg_adr(5'd7));
    endtask

    task automatic ack_timing();
        host_write(reg_adr(5'd5), 32'h1234_5678);
        check_edges("reg write", 1);
        host_read(reg_adr(5'd5));
        check_edges("reg read", 1);
        run_cmd(make_cmd(OP_ADD, 5'd6, 5'd5, 5'd5));
        check_edges("command", 2);   // Extra EXEC cycle
        host_read(ADR_STATUS);
        check_edges("status read", 1);
        host_read(reg_adr(5'd6));
    endtask

    initial begin
        reset  = 1'b1;
        wb_req = '0;
        model_reset();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        read_reset_state();
        finish_test("reset_state");
        reg_write_readback();
        finish_test("reg_access");
        random_alu_cmds();
        finish_test("alu_random");
        mul_div_cmds();
        finish_test("mul_div");
        illegal_and_hilo();
        finish_test("illegal_hilo");
        ack_timing();
        finish_test("ack_timing");
        $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src/mips_exec_top.sv
module mips_exec_top
    import mips_exec_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    // Regfile wires
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  bus_idx;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] bus_rd_data;
    logic        wr_en;
    logic [4:0]  wr_idx;
    logic [31:0] wr_data;

    // ALU wires
    alu_op_e     op;
    logic        hilo_commit;
    logic        hi_wr;
    logic        lo_wr;
    logic [31:0] result;
    logic [31:0] hi;
    logic [31:0] lo;
    alu_flags_t  flags;

    ////////////////////////////////////////
    // Controller, regfile, ALU
    ////////////////////////////////////////

    exec_ctrl exec_ctrl_i (
        .clock(clock),             .reset(reset),
        .wb_req(wb_req),           .wb_rsp(wb_rsp),
        .rs_idx(rs_idx),           .rt_idx(rt_idx),         .bus_idx(bus_idx),
        .rs_data(rs_data),         .rt_data(rt_data),       .bus_rd_data(bus_rd_data),
        .wr_en(wr_en),             .wr_idx(wr_idx),         .wr_data(wr_data),
        .op(op),                   .hilo_commit(hilo_commit),
        .hi_wr(hi_wr),             .lo_wr(lo_wr),
        .result(result),           .hi(hi),                 .lo(lo),
        .flags(flags)
    );

    regfile regfile_i (
        .clock(clock),             .reset(reset),
        .rs_idx(rs_idx),           .rt_idx(rt_idx),         .bus_idx(bus_idx),
        .rs_data(rs_data),         .rt_data(rt_data),       .bus_rd_data(bus_rd_data),
        .wr_en(wr_en),             .wr_idx(wr_idx),         .wr_data(wr_data)
    );

    // Host data feeds HI/LO writes directly
    alu alu_i (
        .clock(clock),             .reset(reset),
        .op(op),                   .a(rs_data),             .b(rt_data),
        .hilo_commit(hilo_commit), .hi_wr(hi_wr),           .lo_wr(lo_wr),
        .bus_data(wb_req.dat),
        .result(result),           .flags(flags),
        .hi(hi),                   .lo(lo)
    );

endmodule

// File: src/exec_ctrl.sv
module exec_ctrl
    import mips_exec_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    // Register file
    output logic [4:0]  rs_idx,
    output logic [4:0]  rt_idx,
    output logic [4:0]  bus_idx,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [31:0] bus_rd_data,
    output logic        wr_en,
    output logic [4:0]  wr_idx,
    output logic [31:0] wr_data,
    // ALU
    output alu_op_e     op,
    output logic        hilo_commit,
    output logic        hi_wr,
    output logic        lo_wr,
    input  logic [31:0] result,
    input  logic [31:0] hi,
    input  logic [31:0] lo,
    input  alu_flags_t  flags
);

    typedef enum logic [1:0] {
        IDLE,   // Waiting for cyc & stb
        EXEC,   // Command in flight
        ACK     // ack high for one cycle
    } state_e;

    state_e      state;
    exec_cmd_t   cmd_q;      // Captured command
    alu_flags_t  flags_q;    // Status register
    logic [31:0] rd_dat_q;   // Read data, valid with ack
    logic [31:0] bus_dat;
    logic        req;        // New transfer seen in IDLE
    logic        sel_reg;
    logic        sel_cmd;
    logic        sel_hi;
    logic        sel_lo;
    logic        sel_status;
    logic        writes_rd;
    logic        writes_hilo;
    logic        exec_ok;    // EXEC with a legal opcode

    ////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////

    assign req        = (state == IDLE) && wb_req.cyc && wb_req.stb;
    assign sel_reg    = (wb_req.adr <= ADR_REG_LAST);
    assign sel_cmd    = (wb_req.adr == ADR_CMD);
    assign sel_hi     = (wb_req.adr == ADR_HI);
    assign sel_lo     = (wb_req.adr == ADR_LO);
    assign sel_status = (wb_req.adr == ADR_STATUS);
    assign bus_idx    = wb_req.adr[6:2];   // Word index

    // Read mux, unmapped and write-only addresses read zero
    always_comb begin
        bus_dat = '0;
        if (sel_reg)    bus_dat = bus_rd_data;
        if (sel_hi)     bus_dat = hi;
        if (sel_lo)     bus_dat = lo;
        if (sel_status) bus_dat = 32'(flags_q);
    end

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////

    assign rs_idx = cmd_q.rs;
    assign rt_idx = cmd_q.rt;
    assign op     = cmd_q.opcode;

    always_comb begin
        writes_rd   = 1'b0;
        writes_hilo = 1'b0;
        case (cmd_q.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT,
            OP_MFHI, OP_MFLO: writes_rd = 1'b1;
            OP_MULTU, OP_DIVU: writes_hilo = 1'b1;
            default: ;   // Illegal, nothing written
        endcase
    end

    assign exec_ok = (state == EXEC) && !flags.illegal;

    // Regfile write port shared by host writes and results
    assign wr_en   = (req && wb_req.we && sel_reg) || (exec_ok && writes_rd);
    assign wr_idx  = (state == EXEC) ? cmd_q.rd : bus_idx;
    assign wr_data = (state == EXEC) ? result : wb_req.dat;

    assign hilo_commit = exec_ok && writes_hilo;
    assign hi_wr       = req && wb_req.we && sel_hi;
    assign lo_wr       = req && wb_req.we && sel_lo;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            cmd_q   <= '0;
            flags_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req && wb_req.we && sel_cmd) begin
                        cmd_q <= exec_cmd_t'(wb_req.dat[$bits(exec_cmd_t)-1:0]);
                        state <= EXEC;
                    end else if (req) begin
                        state <= ACK;   // Single cycle access
                    end
                end
                EXEC: begin
                    flags_q <= flags;   // Latched even for illegal codes
                    state   <= ACK;
                end
                ACK:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Sampled at request, held through EXEC
    always_ff @(posedge clock) begin
        if (req) rd_dat_q <= bus_dat;
    end

    assign wb_rsp = '{ack: (state == ACK), dat: rd_dat_q};

endmodule

// File: src/alu.sv
module alu
    import mips_exec_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  alu_op_e     op,
    input  logic [31:0] a,            // rs
    input  logic [31:0] b,            // rt
    input  logic        hilo_commit,  // Load MULTU/DIVU result
    input  logic        hi_wr,        // Host write to HI
    input  logic        lo_wr,        // Host write to LO
    input  logic [31:0] bus_data,
    output logic [31:0] result,
    output alu_flags_t  flags,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic [63:0] product;   // Full unsigned product
    logic [31:0] quot;
    logic [31:0] rem;
    logic [31:0] hi_next;   // Candidate HI/LO
    logic [31:0] lo_next;
    logic        illegal;

    ////////////////////////////////////////
    // Multiply and divide datapath
    ////////////////////////////////////////

    assign product = 64'(a) * 64'(b);

    // Divide by zero gives 0 and 0
    assign quot = (b == '0) ? '0 : a / b;
    assign rem  = (b == '0) ? '0 : a % b;

    always_comb begin
        case (op)
            OP_MULTU: {hi_next, lo_next} = product;
            OP_DIVU:  {hi_next, lo_next} = {rem, quot};
            default:  {hi_next, lo_next} = {hi, lo};   // Hold
        endcase
    end

    // HI/LO, loaded on commit or by the host
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_commit) begin
            hi <= hi_next;
            lo <= lo_next;
        end else begin
            if (hi_wr) hi <= bus_data;
            if (lo_wr) lo <= bus_data;
        end
    end

    ////////////////////////////////////////
    // Result path
    ////////////////////////////////////////

    assign illegal = (op > OP_MFLO);   // Codes 9..15

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            OP_MFHI: result = hi;
            OP_MFLO: result = lo;
            default: result = '0;   // MULTU, DIVU and illegal codes
        endcase
    end

    // Flags
    always_comb begin
        flags.illegal = illegal;
        case (op)
            OP_MULTU,
            OP_DIVU: flags.zero = ({hi_next, lo_next} == '0);   // Both halves
            default: flags.zero = !illegal && (result == '0);   // Never set when illegal
        endcase
    end

endmodule

// File: src/regfile.sv
module regfile
    import mips_exec_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [4:0]  rs_idx,
    input  logic [4:0]  rt_idx,
    input  logic [4:0]  bus_idx,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] bus_rd_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [31:0] wr_data
);

    logic [31:0] mem [32];   // r0 slot kept but never written

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= '0;
            end
            mem[REG_SP] <= SP_RESET;   // Stack pointer starts at 0x200
        end else if (wr_en && (wr_idx != '0)) begin
            mem[wr_idx] <= wr_data;     // r0 writes dropped
        end
    end

    ////////////////////////////////////////
    // Read ports, combinational
    ////////////////////////////////////////

    // Operand ports for the ALU
    assign rs_data = (rs_idx == '0) ? '0 : mem[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : mem[rt_idx];

    // Host port
    assign bus_rd_data = (bus_idx == '0) ? '0 : mem[bus_idx];

endmodule

// File: src/mips_exec_pkg.sv
package mips_exec_pkg;

    ////////////////////////////////////////
    // Address map, byte addresses
    ////////////////////////////////////////

    localparam logic [7:0] ADR_REG_LAST = 8'h7C;   // r31, r0 sits at 0x00
    localparam logic [7:0] ADR_CMD      = 8'h80;   // Write only
    localparam logic [7:0] ADR_HI       = 8'h84;
    localparam logic [7:0] ADR_LO       = 8'h88;
    localparam logic [7:0] ADR_STATUS   = 8'h8C;   // Read only, {illegal, zero}

    // Stack pointer
    localparam logic [4:0]  REG_SP   = 5'd29;
    localparam logic [31:0] SP_RESET = 32'h0000_0200;

    ////////////////////////////////////////
    // Opcodes and command word
    ////////////////////////////////////////

    // Codes 9 to 15 are illegal
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_SLT   = 4'd4,   // Signed compare
        OP_MULTU = 4'd5,   // {HI, LO} = a * b
        OP_DIVU  = 4'd6,   // HI = rem, LO = quot
        OP_MFHI  = 4'd7,
        OP_MFLO  = 4'd8
    } alu_op_e;

    // Low 19 bits of a write to ADR_CMD
    typedef struct packed {
        alu_op_e    opcode;   // [18:15]
        logic [4:0] rd;       // [14:10]
        logic [4:0] rs;       // [9:5]
        logic [4:0] rt;       // [4:0]
    } exec_cmd_t;

    ////////////////////////////////////////
    // Wishbone classic
    ////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;   // Byte address, word aligned
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Bit 0 zero, bit 1 illegal, same layout as the status register
    typedef struct packed {
        logic illegal;
        logic zero;
    } alu_flags_t;

endpackage
